//--- verilog/x25519_pkg.sv
package x25519_pkg;

	//////////////////////////////
	// Field element geometry

	// Limbs per element, 256 bits total
	localparam int num_limbs = 32;

	// Packed limb size
	localparam int limb_width = 8;

	// Unreduced limb, wide enough for a full pass sum
	localparam int wide_width = 32;

	// 2^256 mod p
	localparam int mul_factor = 38;

	// 2^255 mod p, used when the top limb overflows
	localparam int squeeze_factor = 19;

	// Cycles from pass strobe to pass result
	localparam int pass_latency = 5;

	//////////////////////////////
	// Element types

	typedef struct packed {
		logic [num_limbs-1:0][limb_width-1:0] blocks;
	} bignum_t;

	// One unreduced 32-bit word per limb position
	typedef struct packed {
		logic [num_limbs-1:0][wide_width-1:0] blocks;
	} bignum32_t;

	//////////////////////////////
	// FSM states

	typedef enum logic [0:0] {
		seq_idle,
		seq_issue
	} seq_state_t;

	typedef enum logic [1:0] {
		sq_idle,
		sq_round1,
		sq_round2
	} squeeze_state_t;

endpackage

//--- verilog/mult_pass_if.sv
`timescale 1ns/10ps

// One pass request per cycle, no stall
interface mult_pass_if;

	// Pass strobe
	logic en;

	// Pass index, selects the output limb
	logic [4:0] i;

	// Operand a as latched
	x25519_pkg::bignum_t a;

	// Operand b, rotated so limb j holds b[(i-j) mod 32]
	x25519_pkg::bignum_t b;

	modport source (output en, output i, output a, output b);

	modport sink (input en, input i, input a, input b);

endinterface

//--- verilog/reduction_adder.sv
`timescale 1ns/10ps

// One pipelined level of an adder tree
module reduction_adder #(
	parameter int in_blocks = 32,
	parameter int reduction = 4
) (
	input  logic                                               clk,
	input  logic                                               rst_n,
	input  logic                                               en,
	input  logic [in_blocks*x25519_pkg::wide_width-1:0]        din,
	output logic                                               dout_valid,
	output logic [in_blocks/reduction*x25519_pkg::wide_width-1:0] dout
);

	// Group sums ahead of the output register
	logic [in_blocks/reduction*x25519_pkg::wide_width-1:0] sum;

	//////////////////////////////
	// Group sums

	always_comb begin
		sum = '0;
		for (int g = 0; g < in_blocks / reduction; g++) begin
			// Adjacent words g*reduction up to g*reduction+reduction-1
			for (int k = 0; k < reduction; k++) begin
				sum[g*x25519_pkg::wide_width +: x25519_pkg::wide_width] =
					sum[g*x25519_pkg::wide_width +: x25519_pkg::wide_width] +
					din[(g*reduction + k)*x25519_pkg::wide_width +: x25519_pkg::wide_width];
			end
		end
	end

	//////////////////////////////
	// Output register

	// Strobe follows en by one cycle
	always_ff @(posedge clk) begin
		if (!rst_n)
			dout_valid <= 1'b0;
		else
			dout_valid <= en;
	end

	// Data held between strobes
	always_ff @(posedge clk) begin
		if (en)
			dout <= sum;
	end

endmodule

//--- verilog/mult_sequencer.sv
`timescale 1ns/10ps

module mult_sequencer (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                start,
	input  x25519_pkg::bignum_t a,
	input  x25519_pkg::bignum_t b,
	output logic                busy,
	mult_pass_if.source         pass
);

	x25519_pkg::seq_state_t state;

	// Issue step, runs past 31 while the pipeline drains
	logic [5:0] step;

	x25519_pkg::bignum_t a_q;
	x25519_pkg::bignum_t b_q;
	x25519_pkg::bignum_t b_rot;

	//////////////////////////////
	// Control FSM

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= x25519_pkg::seq_idle;
			step  <= '0;
		end else begin
			case (state)
				x25519_pkg::seq_idle: begin
					if (start) begin
						state <= x25519_pkg::seq_issue;
						step  <= '0;
					end
				end
				x25519_pkg::seq_issue: begin
					// Last pass plus pipeline and collector delay
					if (step == 6'(x25519_pkg::num_limbs + x25519_pkg::pass_latency - 1))
						state <= x25519_pkg::seq_idle;
					step <= step + 6'd1;
				end
				default: state <= x25519_pkg::seq_idle;
			endcase
		end
	end

	// Operands only change on an accepted start
	always_ff @(posedge clk) begin
		if (start && state == x25519_pkg::seq_idle) begin
			a_q <= a;
			b_q <= b;
		end
	end

	//////////////////////////////
	// Rotated operand

	always_comb begin
		for (int j = 0; j < x25519_pkg::num_limbs; j++)
			b_rot.blocks[j] = b_q.blocks[5'(step[4:0] - 5'(j))];
	end

	assign busy    = (state != x25519_pkg::seq_idle);
	assign pass.en = (state == x25519_pkg::seq_issue) && (step < 6'(x25519_pkg::num_limbs));
	assign pass.i  = step[4:0];
	assign pass.a  = a_q;
	assign pass.b  = b_rot;

	// Each burst starts at pass 0
	assert property (@(posedge clk) disable iff (!rst_n)
		$rose(pass.en) |-> pass.i == 5'd0);

	// Indices climb by one with no gaps inside a burst
	assert property (@(posedge clk) disable iff (!rst_n)
		pass.en && pass.i != 5'd0 |-> $past(pass.en) && pass.i == $past(pass.i) + 5'd1);

endmodule

//--- verilog/mult_pass.sv
`timescale 1ns/10ps

module mult_pass (
	input  logic        clk,
	input  logic        rst_n,
	mult_pass_if.sink   pass,
	output logic        out_valid,
	output logic [31:0] out
);

	logic                      stage2_en;
	logic [31:0]               stage2_do38;
	x25519_pkg::bignum32_t     stage2_tmp;
	logic                      stage3_en;
	x25519_pkg::bignum32_t     stage3_tmp;
	logic                      stage4_en;
	logic [8*32-1:0]           stage4_tmp;
	logic                      stage5_en;
	logic [2*32-1:0]           stage5_tmp;

	//////////////////////////////
	// Products and wrap scaling

	mult_pass_stage1 stage1_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.en          (pass.en),
		.i           (pass.i),
		.a           (pass.a),
		.b           (pass.b),
		.stage2_en   (stage2_en),
		.stage2_do38 (stage2_do38),
		.stage2_tmp  (stage2_tmp)
	);

	mult_pass_stage2 stage2_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.stage2_en   (stage2_en),
		.stage2_do38 (stage2_do38),
		.stage2_tmp  (stage2_tmp),
		.stage3_en   (stage3_en),
		.stage3_tmp  (stage3_tmp)
	);

	//////////////////////////////
	// Adder tree, fan-in 4 then 4 then 2

	reduction_adder #(.in_blocks(32), .reduction(4)) stage3_i (
		.clk (clk), .rst_n (rst_n), .en (stage3_en), .din (stage3_tmp),
		.dout_valid (stage4_en), .dout (stage4_tmp)
	);

	reduction_adder #(.in_blocks(8), .reduction(4)) stage4_i (
		.clk (clk), .rst_n (rst_n), .en (stage4_en), .din (stage4_tmp),
		.dout_valid (stage5_en), .dout (stage5_tmp)
	);

	reduction_adder #(.in_blocks(2), .reduction(2)) stage5_i (
		.clk (clk), .rst_n (rst_n), .en (stage5_en), .din (stage5_tmp),
		.dout_valid (out_valid), .dout (out)
	);

	// Fixed latency through all five stages
	assert property (@(posedge clk) disable iff (!rst_n)
		pass.en |-> ##(x25519_pkg::pass_latency) out_valid);

endmodule

// Limb products plus the mask of positions that wrap past 2^256
module mult_pass_stage1 (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  en,
	input  logic [4:0]            i,
	input  x25519_pkg::bignum_t   a,
	input  x25519_pkg::bignum_t   b,
	output logic                  stage2_en,
	output logic [31:0]           stage2_do38,
	output x25519_pkg::bignum32_t stage2_tmp
);

	always_ff @(posedge clk) begin
		if (!rst_n)
			stage2_en <= 1'b0;
		else
			stage2_en <= en;
	end

	// 8x8 products, zero extended into the wide word
	always_ff @(posedge clk) begin
		if (en) begin
			for (int j = 0; j < x25519_pkg::num_limbs; j++) begin
				stage2_do38[j]       <= (j > i);
				stage2_tmp.blocks[j] <= a.blocks[j] * b.blocks[j];
			end
		end
	end

endmodule

// Scale by 38 above the diagonal, pass through below it
module mult_pass_stage2 (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  stage2_en,
	input  logic [31:0]           stage2_do38,
	input  x25519_pkg::bignum32_t stage2_tmp,
	output logic                  stage3_en,
	output x25519_pkg::bignum32_t stage3_tmp
);

	always_ff @(posedge clk) begin
		if (!rst_n)
			stage3_en <= 1'b0;
		else
			stage3_en <= stage2_en;
	end

	always_ff @(posedge clk) begin
		if (stage2_en) begin
			for (int j = 0; j < x25519_pkg::num_limbs; j++) begin
				if (stage2_do38[j])
					stage3_tmp.blocks[j] <= stage2_tmp.blocks[j] * x25519_pkg::mul_factor;
				else
					stage3_tmp.blocks[j] <= stage2_tmp.blocks[j];
			end
		end
	end

endmodule

//--- verilog/limb_collector.sv
`timescale 1ns/10ps

module limb_collector (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  in_valid,
	input  logic [31:0]           in_limb,
	output logic                  full,
	output x25519_pkg::bignum32_t limbs
);

	// Arrival slot, wraps after limb 31
	logic [4:0] count;

	//////////////////////////////
	// Arrival counter and full pulse

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			count <= '0;
			full  <= 1'b0;
		end else begin
			// One cycle after the last limb lands
			full <= in_valid && (count == 5'(x25519_pkg::num_limbs - 1));
			if (in_valid)
				count <= count + 5'd1;
		end
	end

	// Passes arrive in index order
	always_ff @(posedge clk) begin
		if (in_valid)
			limbs.blocks[count] <= in_limb;
	end

	// Next burst cannot start before the squeezer has taken this one
	assert property (@(posedge clk) disable iff (!rst_n)
		full |-> !in_valid);

endmodule

//--- verilog/carry_squeeze.sv
`timescale 1ns/10ps

module carry_squeeze (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  load,
	input  x25519_pkg::bignum32_t limbs,
	output logic                  busy,
	output logic                  done,
	output x25519_pkg::bignum_t   result
);

	x25519_pkg::squeeze_state_t state;

	// Limb under work
	logic [4:0] idx;

	logic [31:0]           carry;
	logic [31:0]           sum;
	x25519_pkg::bignum32_t work;

	// Running carry into the current limb
	assign sum  = carry + work.blocks[idx];
	assign busy = load || (state != x25519_pkg::sq_idle);

	//////////////////////////////
	// Control FSM

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= x25519_pkg::sq_idle;
			idx   <= '0;
			done  <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				x25519_pkg::sq_idle: begin
					idx <= '0;
					if (load)
						state <= x25519_pkg::sq_round1;
				end
				x25519_pkg::sq_round1: begin
					idx <= idx + 5'd1;
					if (idx == 5'(x25519_pkg::num_limbs - 1))
						state <= x25519_pkg::sq_round2;
				end
				x25519_pkg::sq_round2: begin
					idx <= idx + 5'd1;
					if (idx == 5'(x25519_pkg::num_limbs - 1)) begin
						state <= x25519_pkg::sq_idle;
						done  <= 1'b1;
					end
				end
				default: state <= x25519_pkg::sq_idle;
			endcase
		end
	end

	//////////////////////////////
	// Carry datapath

	always_ff @(posedge clk) begin
		if (load) begin
			work  <= limbs;
			carry <= '0;
		end else if (state == x25519_pkg::sq_round1) begin
			if (idx == 5'(x25519_pkg::num_limbs - 1)) begin
				// Bit 255 and up wraps to limb 0 as times 19
				work.blocks[idx] <= sum & 32'h0000_007f;
				carry <= x25519_pkg::squeeze_factor * (sum >> (x25519_pkg::limb_width - 1));
			end else begin
				work.blocks[idx] <= sum & 32'h0000_00ff;
				carry <= sum >> x25519_pkg::limb_width;
			end
		end else if (state == x25519_pkg::sq_round2) begin
			// Top limb is below 256 by now, so it goes out whole
			result.blocks[idx] <= sum[x25519_pkg::limb_width-1:0];
			carry <= sum >> x25519_pkg::limb_width;
		end
	end

	// Collector never hands over mid squeeze
	assert property (@(posedge clk) disable iff (!rst_n)
		load |-> state == x25519_pkg::sq_idle);

	// Two rounds of 32 limbs, then done
	assert property (@(posedge clk) disable iff (!rst_n)
		load |-> ##(2 * x25519_pkg::num_limbs + 1) done);

endmodule

//--- verilog/x25519_mult.sv
`timescale 1ns/10ps

module x25519_mult (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                start,
	input  x25519_pkg::bignum_t a,
	input  x25519_pkg::bignum_t b,
	output logic                busy,
	output logic                done,
	output x25519_pkg::bignum_t result
);

	logic                  seq_busy;
	logic                  sq_busy;
	logic                  pass_valid;
	logic [31:0]           pass_out;
	logic                  limbs_full;
	x25519_pkg::bignum32_t limbs;

	mult_pass_if pass_if ();

	// Start only when the whole chain is empty
	assign busy = seq_busy || sq_busy;

	//////////////////////////////
	// Issue and multiply

	mult_sequencer mult_sequencer_i (
		.clk   (clk),
		.rst_n (rst_n),
		.start (start && !sq_busy),
		.a     (a),
		.b     (b),
		.busy  (seq_busy),
		.pass  (pass_if)
	);

	mult_pass mult_pass_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.pass      (pass_if),
		.out_valid (pass_valid),
		.out       (pass_out)
	);

	//////////////////////////////
	// Gather and reduce

	limb_collector limb_collector_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (pass_valid),
		.in_limb  (pass_out),
		.full     (limbs_full),
		.limbs    (limbs)
	);

	carry_squeeze carry_squeeze_i (
		.clk    (clk),
		.rst_n  (rst_n),
		.load   (limbs_full),
		.limbs  (limbs),
		.busy   (sq_busy),
		.done   (done),
		.result (result)
	);

endmodule

//--- dv/x25519_ref_model.svh
`ifndef X25519_REF_MODEL_SVH
`define X25519_REF_MODEL_SVH

//////////////////////////////
// Expected values for the multiplier

// Schoolbook product, wide limb i collects every a[j]*b[i-j]
// Terms with j above i wrap past 2^256 and come back times 38
function automatic x25519_pkg::bignum32_t model_wide_product(
	input x25519_pkg::bignum_t op_a,
	input x25519_pkg::bignum_t op_b
);
	x25519_pkg::bignum32_t w;
	logic [31:0] term;
	for (int i = 0; i < x25519_pkg::num_limbs; i++) begin
		w.blocks[i] = '0;
		for (int j = 0; j < x25519_pkg::num_limbs; j++) begin
			if (j <= i)
				term = 32'(op_a.blocks[j]) * 32'(op_b.blocks[i - j]);
			else
				term = 32'(x25519_pkg::mul_factor) * 32'(op_a.blocks[j]) *
					32'(op_b.blocks[i + x25519_pkg::num_limbs - j]);
			w.blocks[i] = w.blocks[i] + term;
		end
	end
	return w;
endfunction

// Two carry rounds, first one folds bit 255 and up back in as times 19
function automatic x25519_pkg::bignum_t model_squeeze(input x25519_pkg::bignum32_t w);
	x25519_pkg::bignum_t r;
	logic [31:0] u;
	u = '0;
	for (int j = 0; j < x25519_pkg::num_limbs - 1; j++) begin
		u = u + w.blocks[j];
		w.blocks[j] = u & 32'h0000_00ff;
		u = u >> 8;
	end
	u = u + w.blocks[x25519_pkg::num_limbs - 1];
	w.blocks[x25519_pkg::num_limbs - 1] = u & 32'h0000_007f;
	u = 32'(x25519_pkg::squeeze_factor) * (u >> 7);
	// Carry from the fold runs straight into round two
	for (int j = 0; j < x25519_pkg::num_limbs; j++) begin
		u = u + w.blocks[j];
		r.blocks[j] = u[7:0];
		u = u >> 8;
	end
	return r;
endfunction

function automatic x25519_pkg::bignum_t model_mult(
	input x25519_pkg::bignum_t op_a,
	input x25519_pkg::bignum_t op_b
);
	return model_squeeze(model_wide_product(op_a, op_b));
endfunction

`endif

//--- dv/tb_x25519_mult.sv
`timescale 1ns/10ps

module tb_x25519_mult;

	localparam int clk_period = 20;

	// Multiplications started over the whole run
	localparam int num_runs = 14;
	localparam int cycles_per_run = 200;

	// Longest wait for one done pulse
	localparam int done_limit = 200;

	logic                clk;
	logic                rst_n;
	logic                start;
	x25519_pkg::bignum_t a;
	x25519_pkg::bignum_t b;
	logic                busy;
	logic                done;
	x25519_pkg::bignum_t result;

	logic [31:0] lfsr;
	int          checks;
	int          errors;

	`include "x25519_ref_model.svh"

	x25519_mult x25519_mult_i (
		.clk    (clk),
		.rst_n  (rst_n),
		.start  (start),
		.a      (a),
		.b      (b),
		.busy   (busy),
		.done   (done),
		.result (result)
	);

	//////////////////////////////
	// Clock and watchdog

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	initial begin
		#(num_runs * cycles_per_run * clk_period);
		$display("Watchdog expired at %0t, the tests did not finish in time", $time);
		$display("Checks failed");
		$finish;
	end

	//////////////////////////////
	// Random operands

	// Galois form with taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		else
			return s >> 1;
	endfunction

	// One step per bit
	function automatic logic [7:0] random_byte();
		logic [7:0] v;
		v = '0;
		for (int k = 0; k < 8; k++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[6:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic x25519_pkg::bignum_t random_bignum();
		x25519_pkg::bignum_t v;
		for (int j = 0; j < x25519_pkg::num_limbs; j++)
			v.blocks[j] = random_byte();
		return v;
	endfunction

	//////////////////////////////
	// Compare tasks

	task automatic check_bignum(input string name, input x25519_pkg::bignum_t got,
			input x25519_pkg::bignum_t expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("ERROR %s got %h expected %h at %0t", name, got, expected, $time);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("ERROR %s got %h expected %h at %0t", name, got, expected, $time);
		end
	endtask

	//////////////////////////////
	// Drivers that all return on a falling edge

	// Two rising edges with reset low
	task automatic apply_reset();
		@(negedge clk);
		rst_n <= 1'b0;
		start <= 1'b0;
		repeat (2) @(negedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
	endtask

	// One cycle start strobe
	task automatic drive_start(input x25519_pkg::bignum_t op_a, input x25519_pkg::bignum_t op_b);
		a     <= op_a;
		b     <= op_b;
		start <= 1'b1;
		@(negedge clk);
		start <= 1'b0;
	endtask

	// Stops on the falling edge inside the done pulse
	task automatic wait_done();
		int n;
		n = 0;
		while (done !== 1'b1 && n < done_limit) begin
			@(negedge clk);
			n++;
		end
		if (done !== 1'b1) begin
			errors++;
			$display("No done pulse within %0d cycles at %0t", done_limit, $time);
		end
	endtask

	task automatic run_and_check(input x25519_pkg::bignum_t op_a,
			input x25519_pkg::bignum_t op_b, input x25519_pkg::bignum_t expected);
		drive_start(op_a, op_b);
		wait_done();
		check_bignum("result", result, expected);
	endtask

	//////////////////////////////
	// Directed tests

	// With a = 1 each pass returns b[i] and nothing wraps
	task automatic test_unit_operand();
		x25519_pkg::bignum_t op_a;
		x25519_pkg::bignum_t op_b;
		op_a = '0;
		op_a.blocks[0] = 8'd1;
		op_b = random_bignum();
		// Keep b below 2^255
		op_b.blocks[x25519_pkg::num_limbs - 1][7] = 1'b0;
		run_and_check(op_a, op_b, op_b);
	endtask

	task automatic test_random_operands();
		x25519_pkg::bignum_t op_a;
		x25519_pkg::bignum_t op_b;
		for (int n = 0; n < 8; n++) begin
			op_a = random_bignum();
			op_b = random_bignum();
			run_and_check(op_a, op_b, model_mult(op_a, op_b));
		end
	endtask

	// Largest products and longest carry chains
	task automatic test_all_ones();
		x25519_pkg::bignum_t op_a;
		op_a = '1;
		run_and_check(op_a, op_a, model_mult(op_a, op_a));
	endtask

	// Starts during issue and during squeeze are both dropped
	task automatic test_dropped_start();
		x25519_pkg::bignum_t op_a;
		x25519_pkg::bignum_t op_b;
		x25519_pkg::bignum_t other_a;
		x25519_pkg::bignum_t other_b;
		op_a = random_bignum();
		op_b = random_bignum();
		drive_start(op_a, op_b);
		// Reset while passes are in flight
		repeat (20) @(negedge clk);
		apply_reset();
		check_bit("busy", busy, 1'b0);
		check_bit("done", done, 1'b0);
		op_a    = random_bignum();
		op_b    = random_bignum();
		other_a = random_bignum();
		other_b = random_bignum();
		drive_start(op_a, op_b);
		repeat (8) @(negedge clk);
		check_bit("busy", busy, 1'b1);
		drive_start(other_a, other_b);
		// Past the last pass with the squeezer at work
		repeat (50) @(negedge clk);
		check_bit("busy", busy, 1'b1);
		drive_start(other_a, other_b);
		wait_done();
		check_bignum("result", result, model_mult(op_a, op_b));
		check_bit("busy", busy, 1'b0);
	endtask

	// Second start in the first idle cycle
	task automatic test_back_to_back();
		x25519_pkg::bignum_t first_a;
		x25519_pkg::bignum_t first_b;
		x25519_pkg::bignum_t second_a;
		x25519_pkg::bignum_t second_b;
		first_a  = random_bignum();
		first_b  = random_bignum();
		second_a = random_bignum();
		second_b = random_bignum();
		drive_start(first_a, first_b);
		wait_done();
		check_bignum("result", result, model_mult(first_a, first_b));
		check_bit("busy", busy, 1'b0);
		drive_start(second_a, second_b);
		check_bit("busy", busy, 1'b1);
		wait_done();
		check_bignum("result", result, model_mult(second_a, second_b));
	endtask

	//////////////////////////////
	// Sequence

	initial begin
		rst_n  = 1'b0;
		start  = 1'b0;
		a      = '0;
		b      = '0;
		lfsr   = 32'h6b60_f1ff;
		checks = 0;
		errors = 0;
		apply_reset();
		test_unit_operand();
		test_random_operands();
		test_all_ones();
		test_dropped_start();
		test_back_to_back();
		repeat (4) @(negedge clk);
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

//--- build.f
+incdir+dv
verilog/x25519_pkg.sv
verilog/mult_pass_if.sv
verilog/reduction_adder.sv
verilog/mult_sequencer.sv
verilog/mult_pass.sv
verilog/limb_collector.sv
verilog/carry_squeeze.sv
verilog/x25519_mult.sv
dv/tb_x25519_mult.sv

//--- run_sim.sh
#!/bin/sh
# Build and run with Verilator, pass only if the log holds the pass line
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_x25519_mult -f build.f -o sim_tb \
	&& ./obj_dir/sim_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^All checks passed$" sim.log && echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
